//--- verilog/hex_dump_pkg.sv
package hex_dump_pkg;

    // 16 consecutive samples, oldest in the msb
    typedef logic [15:0] sample_word_t;

    // byte handed from the dump sequencer to the uart
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } uart_byte_t;

    localparam int density_window    = 255; // cycles per density window
    localparam int density_threshold = 224; // ones needed for level_high

    localparam int default_addr_width   = 8;     // 256 capture words
    localparam int default_clks_per_bit = 40000; // 48 MHz at 1200 baud

endpackage

//--- verilog/bit_sampler.sv
module bit_sampler (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sig,
    output hex_dump_pkg::sample_word_t word,
    output logic                       word_stb
);

    logic [14:0] shift;  // the 15 samples before the current one
    logic [3:0]  phase;  // position of the current sample in its word
    logic        last;

    assign last = (phase == 4'd15);

    // control state
    always_ff @(posedge clk) begin
        if (!rst) begin
            phase    <= 4'd0;
            word_stb <= 1'b0;
        end else begin
            phase    <= phase + 4'd1; // wraps after 16 samples
            word_stb <= last;
        end
    end

    // sample payload
    always_ff @(posedge clk) begin
        shift <= {shift[13:0], sig};
        if (last) begin
            word <= {shift, sig}; // newest sample lands in the lsb
        end
    end

endmodule

//--- verilog/density_demod.sv
module density_demod (
    input  logic clk,
    input  logic rst,
    input  logic sig,
    output logic level_high
);

    localparam int win_w = $clog2(hex_dump_pkg::density_window);

    logic [win_w-1:0] win_cnt; // cycle within the window
    logic [win_w-1:0] ones;    // ones seen so far in the window
    logic [win_w:0]   total;   // count including the current sample
    logic             win_end;

    assign total   = {1'b0, ones} + {{win_w{1'b0}}, sig};
    assign win_end = (win_cnt == win_w'(hex_dump_pkg::density_window - 1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            win_cnt    <= '0;
            ones       <= '0;
            level_high <= 1'b0;
        end else if (win_end) begin
            // compare the finished window, then start a fresh one
            level_high <= (total >= (win_w + 1)'(hex_dump_pkg::density_threshold));
            win_cnt    <= '0;
            ones       <= '0;
        end else begin
            win_cnt <= win_cnt + 1'b1;
            ones    <= total[win_w-1:0]; // cannot overflow before the window end
        end
    end

endmodule

//--- verilog/capture_ram.sv
module capture_ram #(
    parameter int addr_width = hex_dump_pkg::default_addr_width
) (
    input  logic                       clk,
    input  logic [addr_width-1:0]      addr,
    input  hex_dump_pkg::sample_word_t wdata,
    input  logic                       we,
    output hex_dump_pkg::sample_word_t rdata
);

    localparam int depth = 2 ** addr_width;

    hex_dump_pkg::sample_word_t mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr]; // old data on a write cycle
    end

endmodule

//--- verilog/dump_sequencer.sv
module dump_sequencer #(
    parameter int addr_width = hex_dump_pkg::default_addr_width
) (
    input  logic                       clk,
    input  logic                       rst,
    input  hex_dump_pkg::sample_word_t word,
    input  logic                       word_stb,
    input  logic                       dump_req,
    input  hex_dump_pkg::sample_word_t rdata,
    input  logic                       credit,
    output logic [addr_width-1:0]      addr,
    output hex_dump_pkg::sample_word_t wdata,
    output logic                       we,
    output hex_dump_pkg::uart_byte_t   tx_byte,
    output logic                       dump_done
);

    typedef enum logic [2:0] {
        st_capture,  // free-running capture, waiting for a request
        st_post,     // post-trigger capture of one full buffer
        st_low,      // send low byte of the word at addr
        st_high,     // send high byte, then step addr
        st_done      // wait for the last byte to reach the shifter
    } state_t;

    state_t                state;
    logic [addr_width-1:0] wr_addr;   // write address, doubles as dump read address
    logic [addr_width-1:0] next_addr;
    logic [addr_width-1:0] end_addr;  // oldest word, where the dump wraps around
    logic [addr_width-1:0] post_cnt;
    logic [1:0]            credits;
    logic                  fetch;     // ram read still in flight
    logic                  capturing;
    logic                  spend;
    logic [7:0]            tx_data;
    logic                  tx_valid;

    assign next_addr = wr_addr + 1'b1;
    assign capturing = (state == st_capture) || (state == st_post);
    assign we        = capturing && word_stb;
    assign addr      = wr_addr;
    assign wdata     = word;
    assign spend     = (credits != 2'd0) &&
                       (((state == st_low) && !fetch) || (state == st_high));

    assign tx_byte.data  = tx_data;
    assign tx_byte.valid = tx_valid;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= st_capture;
            wr_addr   <= '0;
            end_addr  <= '0;
            post_cnt  <= '0;
            fetch     <= 1'b0;
            dump_done <= 1'b0;
        end else begin
            dump_done <= 1'b0;
            if (we) begin
                wr_addr <= next_addr;
            end
            case (state)
                st_capture: begin
                    if (dump_req) begin
                        post_cnt <= '0;
                        state    <= st_post;
                    end
                end
                st_post: begin
                    if (word_stb) begin
                        post_cnt <= post_cnt + 1'b1;
                        if (post_cnt == '1) begin // last post-trigger word
                            end_addr <= next_addr;
                            fetch    <= 1'b1;
                            state    <= st_low;
                        end
                    end
                end
                st_low: begin
                    if (fetch) begin
                        fetch <= 1'b0; // rdata valid from next cycle
                    end else if (spend) begin
                        state <= st_high;
                    end
                end
                st_high: begin
                    if (spend) begin
                        wr_addr <= next_addr;
                        if (next_addr == end_addr) begin
                            state <= st_done;
                        end else begin
                            fetch <= 1'b1;
                            state <= st_low;
                        end
                    end
                end
                st_done: begin
                    if (credits != 2'd0) begin // last byte is in the shifter
                        dump_done <= 1'b1;
                        state     <= st_capture;
                    end
                end
                default: state <= st_capture;
            endcase
        end
    end

    // one credit at start, spent per byte, returned by the uart
    always_ff @(posedge clk) begin
        if (!rst) begin
            credits  <= 2'd1;
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= spend;
            case ({spend, credit})
                2'b10:   credits <= credits - 2'd1;
                2'b01:   credits <= credits + 2'd1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (spend) begin
            tx_data <= (state == st_high) ? rdata[15:8] : rdata[7:0];
        end
    end

endmodule

//--- verilog/uart_tx.sv
module uart_tx #(
    parameter int clks_per_bit = hex_dump_pkg::default_clks_per_bit
) (
    input  logic                     clk,
    input  logic                     rst,
    input  hex_dump_pkg::uart_byte_t tx_byte,
    output logic                     tx_serial,
    output logic                     credit
);

    localparam int cnt_w = $clog2(clks_per_bit);

    logic [7:0]       hold;      // waiting byte
    logic             hold_full;
    logic [8:0]       frame;     // data bits still to go, then the stop bit
    logic             busy;
    logic [cnt_w-1:0] baud_cnt;
    logic [3:0]       bit_cnt;   // 0 start, 1..8 data, 9 stop
    logic             tick;
    logic             frame_end;
    logic             load;
    logic             shift;

    assign tick      = busy && (baud_cnt == cnt_w'(clks_per_bit - 1));
    assign frame_end = tick && (bit_cnt == 4'd9);
    assign load      = hold_full && (!busy || frame_end); // back to back frames
    assign shift     = tick && (bit_cnt != 4'd9);

    always_ff @(posedge clk) begin
        if (!rst) begin
            hold_full <= 1'b0;
            busy      <= 1'b0;
            baud_cnt  <= '0;
            bit_cnt   <= 4'd0;
            tx_serial <= 1'b1;
            credit    <= 1'b0;
        end else begin
            credit <= load;
            if (load) begin
                hold_full <= 1'b0;
                busy      <= 1'b1;
                baud_cnt  <= '0;
                bit_cnt   <= 4'd0;
                tx_serial <= 1'b0; // start bit
            end else if (busy) begin
                if (tick) begin
                    baud_cnt <= '0;
                    if (frame_end) begin
                        busy <= 1'b0;
                    end else begin
                        bit_cnt   <= bit_cnt + 4'd1;
                        tx_serial <= frame[0];
                    end
                end else begin
                    baud_cnt <= baud_cnt + 1'b1;
                end
            end
            if (tx_byte.valid) begin
                hold_full <= 1'b1; // credit rule keeps this from overrunning
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_byte.valid) begin
            hold <= tx_byte.data;
        end
        if (load) begin
            frame <= {1'b1, hold};
        end else if (shift) begin
            frame <= {1'b1, frame[8:1]}; // lsb first
        end
    end

endmodule

//--- verilog/hex_dump.sv
module hex_dump #(
    parameter int addr_width   = hex_dump_pkg::default_addr_width,
    parameter int clks_per_bit = hex_dump_pkg::default_clks_per_bit
) (
    input  logic clk,
    input  logic rst,
    input  logic sig,
    input  logic dump_req,
    output logic tx_serial,
    output logic level_high,
    output logic dump_done
);

    hex_dump_pkg::sample_word_t word;
    logic                       word_stb;
    logic [addr_width-1:0]      ram_addr;
    hex_dump_pkg::sample_word_t ram_wdata;
    hex_dump_pkg::sample_word_t ram_rdata;
    logic                       ram_we;
    hex_dump_pkg::uart_byte_t   tx_byte;
    logic                       credit;

    bit_sampler u_sampler (
        .clk      (clk),
        .rst      (rst),
        .sig      (sig),
        .word     (word),
        .word_stb (word_stb)
    );

    density_demod u_demod (
        .clk        (clk),
        .rst        (rst),
        .sig        (sig),
        .level_high (level_high)
    );

    capture_ram #(
        .addr_width (addr_width)
    ) u_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .we    (ram_we),
        .rdata (ram_rdata)
    );

    dump_sequencer #(
        .addr_width (addr_width)
    ) u_seq (
        .clk       (clk),
        .rst       (rst),
        .word      (word),
        .word_stb  (word_stb),
        .dump_req  (dump_req),
        .rdata     (ram_rdata),
        .credit    (credit),
        .addr      (ram_addr),
        .wdata     (ram_wdata),
        .we        (ram_we),
        .tx_byte   (tx_byte),
        .dump_done (dump_done)
    );

    uart_tx #(
        .clks_per_bit (clks_per_bit)
    ) u_tx (
        .clk       (clk),
        .rst       (rst),
        .tx_byte   (tx_byte),
        .tx_serial (tx_serial),
        .credit    (credit)
    );

endmodule

//--- tb/tb_clock.sv
module tb_clock #(
    parameter int period = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

//--- tb/hex_dump_checker.sv
module hex_dump_checker #(
    parameter int addr_width   = 4,
    parameter int clks_per_bit = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        tx_serial,
    input  logic        dump_done,
    input  logic        level_high,
    input  logic        quiet,               // line must stay idle
    input  logic [15:0] model_words [1024],
    input  int          n_words,
    input  int          n_windows,
    input  logic        exp_level,
    output int          errors,
    output int          dumps_rx,
    output int          done_cnt
);

    localparam int depth = 2 ** addr_width;

    logic        line_q, done_q, busy;
    logic [7:0]  shreg, low_byte;
    logic [15:0] got;
    int          cnt;          // falling edges since the frame start
    int          byte_idx;     // byte position within the current dump
    int          base;         // model index of the oldest dumped word
    int          windows_seen;

    // DUT outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            line_q       = 1'b1;
            done_q       = 1'b0;
            busy         = 1'b0;
            cnt          = 10 * clks_per_bit;
            byte_idx     = 0;
            windows_seen = 0;
            errors       = 0;
            dumps_rx     = 0;
            done_cnt     = 0;
        end else begin
            if (quiet && (tx_serial !== 1'b1 || dump_done !== 1'b0)) begin
                $display("** Error at %0t: line or dump_done active without a request", $time);
                errors++;
            end
            if (!busy) begin
                cnt++;
                busy = line_q && !tx_serial; // falling edge opens a frame
                if (busy) begin
                    if (cnt < 10 * clks_per_bit) begin
                        $display("frame error at %0t: stop bit too short", $time);
                        errors++;
                    end
                    cnt = 0;
                    if (byte_idx == 0) begin
                        base = n_words - depth; // dump holds the newest complete words
                    end
                end
            end else begin
                cnt++;
                if (cnt % clks_per_bit != 0 && tx_serial != line_q) begin
                    $display("frame error at %0t: line changed inside a bit", $time);
                    errors++;
                end
                if (cnt % clks_per_bit == clks_per_bit / 2) begin
                    if (cnt < clks_per_bit) begin
                        if (tx_serial) begin
                            $display("frame error at %0t: start bit is not low", $time);
                            errors++;
                        end
                    end else if (cnt < 9 * clks_per_bit) begin
                        shreg = {tx_serial, shreg[7:1]}; // lsb first
                    end else begin
                        if (!tx_serial) begin
                            $display("frame error at %0t: stop bit is not high", $time);
                            errors++;
                        end
                        busy = 1'b0;
                        if (byte_idx % 2 == 0) begin
                            low_byte = shreg;
                        end else begin
                            got = {shreg, low_byte};
                            if (base < 0) begin
                                $display("dump began before %0d words were captured", depth);
                                errors++;
                            end else if (got !== model_words[base + byte_idx / 2]) begin
                                $display("** Error at %0t: dump word %0d is %h, expected %h",
                                         $time, byte_idx / 2, got,
                                         model_words[base + byte_idx / 2]);
                                errors++;
                            end
                        end
                        byte_idx++;
                        if (byte_idx == 2 * depth) begin
                            byte_idx = 0;
                            dumps_rx++;
                            if (done_cnt != dumps_rx) begin
                                $display("dump_done pulsed %0d times in %0d dumps",
                                         done_cnt, dumps_rx);
                                errors++;
                            end
                        end
                    end
                end
            end
            line_q = tx_serial;
            if (dump_done && done_q) begin
                $display("dump_done stayed high longer than one cycle at %0t", $time);
                errors++;
            end else if (dump_done) begin
                done_cnt++;
                if (!busy || byte_idx != 2 * depth - 1) begin // last frame already started
                    $display("dump_done at %0t did not come with the last byte", $time);
                    errors++;
                end
            end
            done_q = dump_done;
            if (n_windows != windows_seen) begin
                windows_seen = n_windows;
                if (level_high !== exp_level) begin
                    $display("** Error at %0t: level_high is %b, expected %b",
                             $time, level_high, exp_level);
                    errors++;
                end
            end
        end
    end

endmodule

//--- tb/hex_dump_tb.sv
module hex_dump_tb;

    localparam int addr_width   = 4;
    localparam int clks_per_bit = 8;
    localparam int dump_limit   = 10000; // cycles allowed for one dump

    logic        clk, rst, dump_req, tx_serial, level_high, dump_done;
    logic        sig = 1'b0;
    logic        quiet, dense, hung, exp_level;
    logic [31:0] rnd = 32'h80b92828;
    logic [15:0] cur;                     // model of the sampler shift register
    logic [15:0] model_words [1024];
    int          n_samples = 0;
    int          n_words = 0;
    int          n_windows = 0;
    int          win_ones = 0;
    int          errors, dumps_rx, done_cnt;
    int          passed = 0;
    int          failed = 0;
    int          last_errors = 0;

    tb_clock #(.period(100)) u_clock (.clk(clk));

    hex_dump #(.addr_width(addr_width), .clks_per_bit(clks_per_bit)) DUT (.*);

    hex_dump_checker #(.addr_width(addr_width), .clks_per_bit(clks_per_bit)) u_checker (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    always @(negedge clk) begin
        rnd = xorshift32(rnd);
        sig = dense ? (rnd[3:0] != 4'd0) : rnd[0]; // 15/16 or 1/2 ones
    end

    // sample k is taken on the k-th rising edge after reset
    always @(posedge clk) begin
        if (rst) begin
            cur = {cur[14:0], sig}; // oldest sample ends in the msb
            if (n_samples % 16 == 15 && n_words < 1024) begin
                model_words[n_words] = cur;
                n_words++;
            end
            win_ones += int'(sig);
            if (n_samples % hex_dump_pkg::density_window == hex_dump_pkg::density_window - 1) begin
                exp_level = (win_ones >= hex_dump_pkg::density_threshold);
                win_ones  = 0;
                n_windows++;
            end
            n_samples++;
        end
    end

    task automatic report_test(input string name);
        @(posedge clk); // checker counts are stable here
        if (hung || errors != last_errors) begin
            failed++;
            $display("%s: failed with %0d errors", name, errors - last_errors);
        end else begin
            passed++;
            $display("%s: ok", name);
        end
        last_errors = errors;
    endtask

    // one request pulse, then wait until the checker has the whole dump
    task automatic run_dump(input int n);
        int t;
        t = 0;
        @(negedge clk);
        dump_req = 1'b1;
        @(negedge clk);
        dump_req = 1'b0;
        while (dumps_rx < n && t < dump_limit) begin
            @(posedge clk);
            t++;
        end
        if (dumps_rx < n) begin
            $display("timeout: dump %0d did not arrive within %0d cycles", n, dump_limit);
            hung = 1'b1;
        end
    endtask

    initial begin
        rst      = 1'b0;
        dump_req = 1'b0;
        quiet    = 1'b1;
        dense    = 1'b0;
        hung     = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b1;

        repeat (500) @(negedge clk); // no traffic without a request
        report_test("idle after reset");
        quiet = 1'b0;

        run_dump(1);
        report_test("random dump and frame format");
        if (!hung) begin
            run_dump(2);
            report_test("dump_done and second dump");
        end
        if (!hung) begin
            dense = 1'b1;
            repeat (4 * hex_dump_pkg::density_window) @(negedge clk);
            report_test("density at 15/16");
            dense = 1'b0;
            repeat (4 * hex_dump_pkg::density_window) @(negedge clk);
            report_test("density at 1/2");
        end

        $display("%0d tests passed, %0d failed, %0d check errors", passed, failed, errors);
        if (!hung && failed == 0 && errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
verilog/hex_dump_pkg.sv
verilog/bit_sampler.sv
verilog/density_demod.sv
verilog/capture_ram.sv
verilog/dump_sequencer.sv
verilog/uart_tx.sv
verilog/hex_dump.sv
tb/tb_clock.sv
tb/hex_dump_checker.sv
tb/hex_dump_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the hex_dump testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module hex_dump_tb -f build.f -o hex_dump_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/hex_dump_sim); then
    echo "$out"
    echo "simulation exited with an error"
    exit 1
fi
echo "$out"

if echo "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1
